//--- bench/decode_issue_asserts.sv
/*
  Concurrent checks on the issue register outputs, bound into issue_steer.
  Assumes the pipe count from the shared constants header.
*/
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decode_issue_asserts (
  input logic                    clk,
  input logic                    rst,
  input logic                    full,
  input logic                    unissuable,
  input logic [`NUM_PIPES-1:0]   x_val,
  input logic [`NUM_PIPES-1:0]   x_rdy,
  input logic [`XLEN-1:0]        x_pc,
  input logic [`UOP_W-1:0]       x_uop,
  input logic [`XLEN-1:0]        x_op1,
  input logic [`XLEN-1:0]        x_op2,
  input logic [`XLEN-1:0]        x_imm,
  input logic [`REG_ADDR_W-1:0]  x_waddr,
  input logic                    x_wen
);

  // At most one pipe offered a message
  a_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(x_val))
    else $error("x_val has more than one bit set");

  // Held message not taken by any pipe, so it stays and keeps its payload
  a_stable: assert property (@(posedge clk) disable iff (rst)
    (full && !unissuable && !(|(x_val & x_rdy))) |=>
      (full && $stable({x_pc, x_uop, x_op1, x_op2, x_imm, x_waddr, x_wen})))
    else $error("Issue message changed while waiting for a pipe");

  // Empty issue register right after reset
  a_reset: assert property (@(posedge clk) $fell(rst) |-> (x_val == '0))
    else $error("x_val raised in the first cycle after reset");

endmodule

bind issue_steer decode_issue_asserts u_issue_asserts (
  .clk        (clk),
  .rst        (rst),
  .full       (full),
  .unissuable (unissuable),
  .x_val      (x_val),
  .x_rdy      (x_rdy),
  .x_pc       (x_pc),
  .x_uop      (x_uop),
  .x_op1      (x_op1),
  .x_op2      (x_op2),
  .x_imm      (x_imm),
  .x_waddr    (x_waddr),
  .x_wen      (x_wen)
);

`default_nettype wire

//--- bench/decode_issue_tb.sv
/*
  Random instruction stream against a reference decoder and register model.
  First instructions stream with every pipe ready and all masks open.
*/
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decode_issue_tb;

  localparam int N_INSTS = 3000;
  localparam int BURST   = 200;
  localparam int PERIOD  = 8;

  // RV32 major opcodes
  localparam logic [6:0] OP_R   = 7'b0110011;
  localparam logic [6:0] OP_I   = 7'b0010011;
  localparam logic [6:0] OP_LD  = 7'b0000011;
  localparam logic [6:0] OP_ST  = 7'b0100011;
  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [6:0] OP_JR  = 7'b1100111;
  localparam logic [6:0] OP_BR  = 7'b1100011;

  typedef struct packed {
    logic [31:0] pc;
    logic [2:0]  uop;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] imm;
    logic [4:0]  waddr;
    logic        wen;
  } msg_t;

  logic clk;
  logic rst;
  logic f_val;
  logic f_rdy;
  logic [31:0] f_pc;
  logic [31:0] f_inst;
  logic [31:0] x_pc;
  logic [2:0]  x_uop;
  logic [31:0] x_op1;
  logic [31:0] x_op2;
  logic [31:0] x_imm;
  logic [4:0]  x_waddr;
  logic        x_wen;
  logic [`NUM_PIPES-1:0] x_val;
  logic [`NUM_PIPES-1:0] x_rdy;
  logic        wb_en;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic        cfg_we;
  logic [1:0]  cfg_idx;
  logic [6:0]  cfg_mask;
  logic        illegal;
  logic        unissuable;

  // Reference state
  logic [31:0] lcg_state;
  logic [31:0] model_regs [0:31];
  logic [6:0]  masks [0:`NUM_PIPES-1];
  msg_t        msg_q [$];
  logic        ill_due;
  logic [31:0] pc_next;
  logic        done;
  int          accepted;
  int          delivered;
  int          n_illegal;
  int          n_uniss;
  int          mismatch_count;
  int          other_count;

  decode_issue_top i_dut (
    .clk (clk), .rst (rst),
    .f_val (f_val), .f_rdy (f_rdy), .f_pc (f_pc), .f_inst (f_inst),
    .x_pc (x_pc), .x_uop (x_uop), .x_op1 (x_op1), .x_op2 (x_op2),
    .x_imm (x_imm), .x_waddr (x_waddr), .x_wen (x_wen),
    .x_val (x_val), .x_rdy (x_rdy),
    .wb_en (wb_en), .wb_addr (wb_addr), .wb_data (wb_data),
    .cfg_we (cfg_we), .cfg_idx (cfg_idx), .cfg_mask (cfg_mask),
    .illegal (illegal), .unissuable (unissuable)
  );

  always #(PERIOD / 2) clk = ~clk;

  //------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------
  // LCG, halves swapped so low bits are usable
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      mismatch_count++;
    end
  endtask

  // Register value seen at this edge, write bypass included
  function automatic logic [31:0] read_model(input logic [4:0] a);
    if (a == 5'd0) begin
      return 32'd0;
    end
    if (wb_en && wb_addr == a) begin
      return wb_data;
    end
    return model_regs[a];
  endfunction

  // Random word of one of the eight kinds, or an illegal one
  function automatic logic [31:0] make_inst();
    logic [31:0] r;
    logic [3:0]  kind;
    r = next_rand();
    kind = 4'(next_rand() % 9);
    // Keep sources in x0..x7 so writebacks hit them
    if (kind != 4'd5) begin
      r[24:23] = 2'b00;
      r[19:18] = 2'b00;
    end
    case (kind)
      4'd0: return {7'b0000000, r[24:15], 3'b000, r[11:7], OP_R};
      4'd1: return {r[31:15], 3'b000, r[11:7], OP_I};
      4'd2: return {7'b0000001, r[24:15], 3'b000, r[11:7], OP_R};
      4'd3: return {r[31:15], 3'b010, r[11:7], OP_LD};
      4'd4: return {r[31:15], 3'b010, r[11:7], OP_ST};
      4'd5: return {r[31:7], OP_JAL};
      4'd6: return {r[31:15], 3'b000, r[11:7], OP_JR};
      4'd7: return {r[31:15], 3'b001, r[11:7], OP_BR};
      // System opcode, or beq which the subset lacks
      default: return r[0] ? {r[31:7], 7'b1110011} : {r[31:15], 3'b000, r[11:7], OP_BR};
    endcase
  endfunction

  // Reference decode of one fetched word
  task automatic decode_word(input logic [31:0] w, input logic [31:0] pc,
                             output logic legal, output msg_t m);
    logic        use_rs2;
    logic [31:0] imm_i;
    imm_i   = {{20{w[31]}}, w[31:20]};
    legal   = 1'b0;
    use_rs2 = 1'b0;
    m       = '0;
    m.pc    = pc;
    case (w[6:0])
      OP_R: begin
        use_rs2 = 1'b1;
        legal = (w[14:12] == 3'b000) && (w[31:25] == 7'd0 || w[31:25] == 7'd1);
        m.uop = (w[31:25] == 7'd1) ? `UOP_MUL : `UOP_ADD;
      end
      OP_I: begin
        legal = (w[14:12] == 3'b000);
        m.uop = `UOP_ADD;
        m.imm = imm_i;
      end
      OP_LD: begin
        legal = (w[14:12] == 3'b010);
        m.uop = `UOP_LW;
        m.imm = imm_i;
      end
      OP_ST: begin
        legal = (w[14:12] == 3'b010);
        use_rs2 = 1'b1;
        m.uop = `UOP_SW;
        m.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      end
      OP_JAL: begin
        legal = 1'b1;
        m.uop = `UOP_JAL;
        m.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      OP_JR: begin
        legal = (w[14:12] == 3'b000);
        m.uop = `UOP_JALR;
        m.imm = imm_i;
      end
      OP_BR: begin
        legal = (w[14:12] == 3'b001);
        use_rs2 = 1'b1;
        m.uop = `UOP_BNE;
        m.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      end
      default: legal = 1'b0;
    endcase
    m.op1   = (m.uop == `UOP_JAL) ? pc : read_model(w[19:15]);
    m.op2   = use_rs2 ? read_model(w[24:20]) : m.imm;
    m.wen   = (m.uop != `UOP_SW) && (m.uop != `UOP_BNE);
    m.waddr = m.wen ? w[11:7] : 5'd0;
  endtask

  //------------------------------------------------------------
  // Per-edge check, model update and next drive
  //------------------------------------------------------------
  always @(posedge clk) begin : step
    logic [`NUM_PIPES-1:0] exp_xval;
    logic exp_uniss;
    logic exp_frdy;
    logic any_cov;
    logic legal;
    logic hold;
    msg_t m;
    msg_t head;
    if (!rst && !done) begin
      // Expected steering of the held message
      exp_xval = '0;
      any_cov  = 1'b0;
      head     = '0;
      if (msg_q.size() != 0) begin
        head = msg_q[0];
        for (int p = 0; p < `NUM_PIPES; p++) begin
          if (masks[p][head.uop]) begin
            any_cov = 1'b1;
            if (x_rdy[p] && exp_xval == '0) begin
              exp_xval[p] = 1'b1;
            end
          end
        end
      end
      exp_uniss = (msg_q.size() != 0) && !any_cov;
      exp_frdy  = (msg_q.size() == 0) || (exp_xval != '0) || exp_uniss;
      check_value("x_val", 32'(x_val), 32'(exp_xval));
      check_value("unissuable", 32'(unissuable), 32'(exp_uniss));
      check_value("f_rdy", 32'(f_rdy), 32'(exp_frdy));
      check_value("illegal", 32'(illegal), 32'(ill_due));
      if (accepted < BURST && accepted > 0 && f_val && !f_rdy) begin
        $display("Fetch stalled at %0t during the all-ready stream", $time);
        other_count++;
      end
      // Delivery or drop of the head
      if (exp_xval != '0) begin
        check_value("x_pc", x_pc, head.pc);
        check_value("x_uop", 32'(x_uop), 32'(head.uop));
        check_value("x_op1", x_op1, head.op1);
        check_value("x_op2", x_op2, head.op2);
        check_value("x_imm", x_imm, head.imm);
        check_value("x_waddr", 32'(x_waddr), 32'(head.waddr));
        check_value("x_wen", 32'(x_wen), 32'(head.wen));
        void'(msg_q.pop_front());
        delivered++;
      end else if (exp_uniss) begin
        void'(msg_q.pop_front());
        n_uniss++;
      end
      // Mask write lands at this edge
      if (cfg_we && cfg_idx < 2'(`NUM_PIPES)) begin
        masks[cfg_idx] = cfg_mask;
      end
      // Fetch transfer
      ill_due = 1'b0;
      hold = f_val && !exp_frdy;
      if (f_val && exp_frdy) begin
        decode_word(f_inst, f_pc, legal, m);
        if (legal) begin
          msg_q.push_back(m);
        end else begin
          ill_due = 1'b1;
          n_illegal++;
        end
        accepted++;
      end
      if (wb_en && wb_addr != 5'd0) begin
        model_regs[wb_addr] = wb_data;
      end
      // Next inputs
      cfg_we <= 1'b0;
      if (hold) begin
        // Valid word waits for the stage
      end else if (accepted >= N_INSTS) begin
        f_val <= 1'b0;
        if (msg_q.size() == 0 && !f_val) begin
          done <= 1'b1;
        end
      end else if (accepted >= BURST && next_rand() % 4 == 0) begin
        f_val <= 1'b0;
        // Masks change only with the issue register empty
        if (msg_q.size() == 0 && next_rand() % 2 == 0) begin
          cfg_we   <= 1'b1;
          cfg_idx  <= 2'(next_rand() % 4);
          cfg_mask <= (next_rand() % 4 == 0) ? 7'h7f : 7'(next_rand());
        end
      end else begin
        f_val   <= 1'b1;
        f_pc    <= pc_next;
        f_inst  <= make_inst();
        pc_next = pc_next + 32'd4;
      end
      if (accepted < BURST) begin
        x_rdy <= '1;
      end else begin
        for (int p = 0; p < `NUM_PIPES; p++) begin
          x_rdy[p] <= (next_rand() % 4 != 0);
        end
      end
      wb_en   <= next_rand() % 2 == 0;
      wb_addr <= {2'b00, 3'(next_rand())};
      wb_data <= next_rand();
    end
  end

  //------------------------------------------------------------
  // Reset, end of run and watchdog
  //------------------------------------------------------------
  initial begin
    clk = 1'b0;
    rst = 1'b1;
    f_val = 1'b0;
    f_pc = '0;
    f_inst = '0;
    x_rdy = '0;
    wb_en = 1'b0;
    wb_addr = '0;
    wb_data = '0;
    cfg_we = 1'b0;
    cfg_idx = '0;
    cfg_mask = '0;
    lcg_state = 32'h2c92_d55c;
    ill_due = 1'b0;
    pc_next = `RST_ADDR;
    done = 1'b0;
    accepted = 0;
    delivered = 0;
    n_illegal = 0;
    n_uniss = 0;
    mismatch_count = 0;
    other_count = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int p = 0; p < `NUM_PIPES; p++) begin
      masks[p] = 7'h7f;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    wait (done);
    repeat (4) @(posedge clk);
    $display("Errors: %0d mismatches, %0d other; %0d in, %0d out, %0d illegal, %0d unissuable",
             mismatch_count, other_count, accepted, delivered, n_illegal, n_uniss);
    if (mismatch_count == 0 && other_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Forty cycles per instruction is far past the worst stall
  initial begin
    #(N_INSTS * 40 * PERIOD);
    $display("Run timed out with %0d of %0d instructions accepted", accepted, N_INSTS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the decode-and-issue testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module decode_issue_tb \
  -Mdir obj_dir \
  -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vdecode_issue_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
  echo "No verdict found in $LOG"
  exit 1
fi
exit 0

//--- source/decode_consts.svh
/*
  Shared widths and micro-op codes for the decode-and-issue stage.
  Micro-op codes must stay dense from 0 so they index the op mask.
*/
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Datapath and pipe sizing
`define XLEN        32
`define NUM_PIPES   3
`define RST_ADDR    32'h0000_0000
`define REG_ADDR_W  5
`define NUM_REGS    32

// Micro-op encoding
`define UOP_W       3
`define NUM_UOPS    7
`define UOP_ADD     3'd0
`define UOP_MUL     3'd1
`define UOP_LW      3'd2
`define UOP_SW      3'd3
`define UOP_JAL     3'd4
`define UOP_JALR    3'd5
`define UOP_BNE     3'd6

`endif

//--- source/decode_ifs.sv
/*
  Decode-to-issue message bus with valid/ready, and the combinational
  register file read bus. A transfer needs val and rdy high at an edge.
*/
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

// Decoded message toward the issue register
interface dec_issue_if;
  logic                    val;
  logic                    rdy;
  logic [`XLEN-1:0]        pc;
  issue_pkg::uop_t         uop;
  logic [`XLEN-1:0]        op1;
  logic [`XLEN-1:0]        op2;
  logic [`XLEN-1:0]        imm;
  logic [`REG_ADDR_W-1:0]  waddr;
  logic                    wen;

  modport dec (output val, pc, uop, op1, op2, imm, waddr, wen, input rdy);
  modport iss (input val, pc, uop, op1, op2, imm, waddr, wen, output rdy);
endinterface

// Two read ports, data valid in the same cycle
interface rf_read_if;
  logic [`REG_ADDR_W-1:0]  raddr0;
  logic [`REG_ADDR_W-1:0]  raddr1;
  logic [`XLEN-1:0]        rdata0;
  logic [`XLEN-1:0]        rdata1;

  modport dec (output raddr0, raddr1, input rdata0, rdata1);
  modport rf  (input raddr0, raddr1, output rdata0, rdata1);
endinterface

`default_nettype wire

//--- source/decode_issue_top.sv
/*
  Decode-and-issue stage top. Fetch and execute sides are valid/ready;
  the x bus is shared, x_val and x_rdy have one bit per pipe.
  Writeback ordering against issued reads is left to the caller.
*/
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decode_issue_top (
  input  logic                                 clk,
  input  logic                                 rst,
  // Fetch side
  input  logic                                 f_val,
  output logic                                 f_rdy,
  input  logic [`XLEN-1:0]                     f_pc,
  input  logic [`XLEN-1:0]                     f_inst,
  // Execute side
  output logic [`XLEN-1:0]                     x_pc,
  output issue_pkg::uop_t                      x_uop,
  output logic [`XLEN-1:0]                     x_op1,
  output logic [`XLEN-1:0]                     x_op2,
  output logic [`XLEN-1:0]                     x_imm,
  output logic [`REG_ADDR_W-1:0]               x_waddr,
  output logic                                 x_wen,
  output logic [`NUM_PIPES-1:0]                x_val,
  input  logic [`NUM_PIPES-1:0]                x_rdy,
  // Writeback
  input  logic                                 wb_en,
  input  logic [`REG_ADDR_W-1:0]               wb_addr,
  input  logic [`XLEN-1:0]                     wb_data,
  // Pipe mask configuration
  input  logic                                 cfg_we,
  input  logic [$clog2(`NUM_PIPES)-1:0]        cfg_idx,
  input  issue_pkg::op_vec_t                   cfg_mask,
  // Status pulses
  output logic                                 illegal,
  output logic                                 unissuable
);
  import issue_pkg::*;

  op_vec_t [`NUM_PIPES-1:0] pipe_masks;

  dec_issue_if dq ();
  rf_read_if   rf ();

  reg_file u_reg_file (
    .clk     (clk),
    .rst     (rst),
    .rd      (rf.rf),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

  inst_decoder u_inst_decoder (
    .clk     (clk),
    .rst     (rst),
    .f_val   (f_val),
    .f_pc    (f_pc),
    .f_inst  (f_inst),
    .f_rdy   (f_rdy),
    .illegal (illegal),
    .rf      (rf.dec),
    .dq      (dq.dec)
  );

  pipe_cfg_regs u_pipe_cfg_regs (
    .clk        (clk),
    .rst        (rst),
    .cfg_we     (cfg_we),
    .cfg_idx    (cfg_idx),
    .cfg_mask   (cfg_mask),
    .pipe_masks (pipe_masks)
  );

  issue_steer #(
    .num_pipes (`NUM_PIPES)
  ) u_issue_steer (
    .clk        (clk),
    .rst        (rst),
    .dq         (dq.iss),
    .pipe_masks (pipe_masks),
    .x_pc       (x_pc),
    .x_uop      (x_uop),
    .x_op1      (x_op1),
    .x_op2      (x_op2),
    .x_imm      (x_imm),
    .x_waddr    (x_waddr),
    .x_wen      (x_wen),
    .x_val      (x_val),
    .x_rdy      (x_rdy),
    .unissuable (unissuable)
  );

endmodule

`default_nettype wire

//--- source/inst_decoder.sv
/*
  Decodes one TinyRV1 word per fetch transfer into a micro-op message.
  Illegal words never raise val; they are consumed and pulse illegal.
  For jal, op1 is the PC and op2 the J immediate.
*/
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module inst_decoder (
  input  logic              clk,
  input  logic              rst,
  input  logic              f_val,
  input  logic [`XLEN-1:0]  f_pc,
  input  logic [`XLEN-1:0]  f_inst,
  output logic              f_rdy,
  output logic              illegal,
  rf_read_if.dec            rf,
  dec_issue_if.dec          dq
);
  import rv_isa_pkg::*;
  import issue_pkg::*;

  rv_inst_t          inst;
  uop_t              uop;
  logic              legal;
  logic              sel_rs2;
  logic              wen;
  logic [`XLEN-1:0]  imm;
  logic [`XLEN-1:0]  imm_i;
  logic [`XLEN-1:0]  imm_s;
  logic [`XLEN-1:0]  imm_b;
  logic [`XLEN-1:0]  imm_j;

  assign inst = rv_inst_t'(f_inst);

  //------------------------------------------------------------
  // Immediate forms
  //------------------------------------------------------------
  assign imm_i = {{(`XLEN-12){inst.imm_fmt.imm[11]}}, inst.imm_fmt.imm};
  // S and B share the funct7 and rd slots of the R layout
  assign imm_s = {{(`XLEN-12){inst.r_fmt.funct7[6]}}, inst.r_fmt.funct7, inst.r_fmt.rd};
  assign imm_b = {{(`XLEN-12){inst.r_fmt.funct7[6]}}, inst.r_fmt.rd[0],
                  inst.r_fmt.funct7[5:0], inst.r_fmt.rd[4:1], 1'b0};
  // J immediate bits 19:12 sit where rs1 and funct3 live
  assign imm_j = {{(`XLEN-20){inst.imm_fmt.imm[11]}}, inst.imm_fmt.rs1,
                  inst.imm_fmt.funct3, inst.imm_fmt.imm[0], inst.imm_fmt.imm[10:1], 1'b0};

  //------------------------------------------------------------
  // Micro-op, legality and operand source
  //------------------------------------------------------------
  always_comb begin
    uop     = `UOP_ADD;
    legal   = 1'b0;
    sel_rs2 = 1'b0;
    imm     = '0;
    case (inst.r_fmt.opcode)
      OPC_OP: begin
        sel_rs2 = 1'b1;
        if (inst.r_fmt.funct3 == F3_ADD) begin
          if (inst.r_fmt.funct7 == FUNCT7_BASE) begin
            legal = 1'b1;
          end else if (inst.r_fmt.funct7 == FUNCT7_MULDIV) begin
            uop   = `UOP_MUL;
            legal = 1'b1;
          end
        end
      end
      OPC_OP_IMM: begin
        // addi rides on the add micro-op
        legal = (inst.imm_fmt.funct3 == F3_ADD);
        imm   = imm_i;
      end
      OPC_LOAD: begin
        uop   = `UOP_LW;
        legal = (inst.imm_fmt.funct3 == F3_WORD);
        imm   = imm_i;
      end
      OPC_STORE: begin
        uop     = `UOP_SW;
        legal   = (inst.r_fmt.funct3 == F3_WORD);
        sel_rs2 = 1'b1;
        imm     = imm_s;
      end
      OPC_JAL: begin
        uop   = `UOP_JAL;
        legal = 1'b1;
        imm   = imm_j;
      end
      OPC_JALR: begin
        uop   = `UOP_JALR;
        legal = (inst.imm_fmt.funct3 == F3_JALR);
        imm   = imm_i;
      end
      OPC_BRANCH: begin
        uop     = `UOP_BNE;
        legal   = (inst.r_fmt.funct3 == F3_BNE);
        sel_rs2 = 1'b1;
        imm     = imm_b;
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  // No destination for store and branch
  assign wen = (uop != `UOP_SW) && (uop != `UOP_BNE);

  // Source registers always come from the R layout slots
  assign rf.raddr0 = inst.r_fmt.rs1;
  assign rf.raddr1 = inst.r_fmt.rs2;

  //------------------------------------------------------------
  // Message toward issue
  //------------------------------------------------------------
  assign dq.val   = f_val & legal;
  assign dq.pc    = f_pc;
  assign dq.uop   = uop;
  assign dq.op1   = (uop == `UOP_JAL) ? f_pc : rf.rdata0;
  assign dq.op2   = sel_rs2 ? rf.rdata1 : imm;
  assign dq.imm   = imm;
  assign dq.wen   = wen;
  assign dq.waddr = wen ? inst.r_fmt.rd : '0;

  // Fetch is ready exactly when the issue register can take a word
  assign f_rdy = dq.rdy;

  // Pulse in the cycle after an illegal word is consumed
  always_ff @(posedge clk) begin
    if (rst) begin
      illegal <= 1'b0;
    end else begin
      illegal <= f_val & ~legal & dq.rdy;
    end
  end

endmodule

`default_nettype wire

//--- source/issue_pkg.sv
/*
  Micro-op and op-mask types shared by decode, issue and configuration.
  Mask bit k stands for micro-op code k.
*/
`default_nettype none

`include "decode_consts.svh"

package issue_pkg;

  // Micro-op code as carried on the issue bus
  typedef logic [`UOP_W-1:0] uop_t;

  // One bit per micro-op, set where a pipe accepts it
  typedef logic [`NUM_UOPS-1:0] op_vec_t;

  //------------------------------------------------------------
  // Micro-op to one-hot mask
  //------------------------------------------------------------
  // Codes past the last micro-op map to an empty mask
  function automatic op_vec_t uop_to_vec(input uop_t uop);
    op_vec_t vec;
    vec = '0;
    if (int'(uop) < `NUM_UOPS) begin
      vec[uop] = 1'b1;
    end
    return vec;
  endfunction

endpackage

`default_nettype wire

//--- source/issue_steer.sv
/*
  Single-entry issue register with steering to execute pipes.
  Delivery goes to the lowest ready pipe whose mask covers the micro-op;
  a message that no mask covers is dropped with a one-cycle pulse.
*/
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module issue_steer #(
  parameter int num_pipes = `NUM_PIPES
) (
  input  logic                                   clk,
  input  logic                                   rst,
  dec_issue_if.iss                               dq,
  input  issue_pkg::op_vec_t [num_pipes-1:0]     pipe_masks,
  output logic [`XLEN-1:0]                       x_pc,
  output issue_pkg::uop_t                        x_uop,
  output logic [`XLEN-1:0]                       x_op1,
  output logic [`XLEN-1:0]                       x_op2,
  output logic [`XLEN-1:0]                       x_imm,
  output logic [`REG_ADDR_W-1:0]                 x_waddr,
  output logic                                   x_wen,
  output logic [num_pipes-1:0]                   x_val,
  input  logic [num_pipes-1:0]                   x_rdy,
  output logic                                   unissuable
);
  import issue_pkg::*;

  logic                  full;
  logic                  deliver;
  logic [num_pipes-1:0]  covered;
  logic [num_pipes-1:0]  ready_cov;

  //------------------------------------------------------------
  // Mask coverage and pipe choice
  //------------------------------------------------------------
  for (genvar p = 0; p < num_pipes; p++) begin : g_cover
    assign covered[p] = |(pipe_masks[p] & uop_to_vec(x_uop));
  end

  assign ready_cov = covered & x_rdy;

  // Isolate lowest set bit
  assign x_val = full ? (ready_cov & (~ready_cov + 1'b1)) : '0;

  assign deliver    = |x_val;
  assign unissuable = full & ~|covered;

  // Room when empty, or the held message leaves this cycle
  assign dq.rdy = ~full | deliver | unissuable;

  //------------------------------------------------------------
  // Issue register
  //------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (dq.rdy) begin
      full <= dq.val;
    end
  end

  // Idle PC reads as the reset address
  always_ff @(posedge clk) begin
    if (rst) begin
      x_pc <= `RST_ADDR;
    end else if (dq.rdy && dq.val) begin
      x_pc <= dq.pc;
    end
  end

  // Payload held unchanged under back-pressure
  always_ff @(posedge clk) begin
    if (dq.rdy && dq.val) begin
      x_uop   <= dq.uop;
      x_op1   <= dq.op1;
      x_op2   <= dq.op2;
      x_imm   <= dq.imm;
      x_waddr <= dq.waddr;
      x_wen   <= dq.wen;
    end
  end

endmodule

`default_nettype wire

//--- source/pipe_cfg_regs.sv
/*
  One accepted-op mask per execute pipe, all ones after reset.
  A write with an index past the last pipe changes nothing.
*/
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module pipe_cfg_regs (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      cfg_we,
  input  logic [$clog2(`NUM_PIPES)-1:0]             cfg_idx,
  input  issue_pkg::op_vec_t                        cfg_mask,
  output issue_pkg::op_vec_t [`NUM_PIPES-1:0]       pipe_masks
);

  // Index check against the real pipe count
  logic idx_ok;

  assign idx_ok = (int'(cfg_idx) < `NUM_PIPES);

  always_ff @(posedge clk) begin
    if (rst) begin
      // Every pipe takes every micro-op
      for (int p = 0; p < `NUM_PIPES; p++) begin
        pipe_masks[p] <= '1;
      end
    end else if (cfg_we && idx_ok) begin
      pipe_masks[cfg_idx] <= cfg_mask;
    end
  end

endmodule

`default_nettype wire

//--- source/reg_file.sv
/*
  31 general registers plus a hard zero at x0. Writes land at the edge;
  reads are combinational and see a same-cycle write through the bypass.
*/
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module reg_file (
  input  logic                    clk,
  input  logic                    rst,
  rf_read_if.rf                   rd,
  input  logic                    wb_en,
  input  logic [`REG_ADDR_W-1:0]  wb_addr,
  input  logic [`XLEN-1:0]        wb_data
);

  // x0 has no storage
  logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && (wb_addr != '0)) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // Read with writeback forwarding
  function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    if (wb_en && (wb_addr == addr)) begin
      return wb_data;
    end
    return regs[addr];
  endfunction

  assign rd.rdata0 = read_port(rd.raddr0);
  assign rd.rdata1 = read_port(rd.raddr1);

endmodule

`default_nettype wire

//--- source/rv_isa_pkg.sv
/*
  RV32 instruction word views and the opcode and funct values that
  the TinyRV1 subset needs. Other RV32 encodings are not listed.
*/
`default_nettype none

package rv_isa_pkg;

  // One fetched word, two field layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } imm_fmt;
  } rv_inst_t;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct7 and funct3 selectors
  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
  localparam logic [2:0] F3_ADD        = 3'b000;
  localparam logic [2:0] F3_WORD       = 3'b010;
  localparam logic [2:0] F3_JALR       = 3'b000;
  localparam logic [2:0] F3_BNE        = 3'b001;

endpackage

`default_nettype wire

//--- sources.f
+incdir+source
source/rv_isa_pkg.sv
source/issue_pkg.sv
source/decode_ifs.sv
source/reg_file.sv
source/inst_decoder.sv
source/pipe_cfg_regs.sv
source/issue_steer.sv
source/decode_issue_top.sv
bench/decode_issue_asserts.sv
bench/decode_issue_tb.sv
